// File: hdl/vpu_pkg.sv
package vpu_pkg;

	localparam int LANES = 4;
	localparam int REG_BITS = 5;
	localparam int INSTR_WIDTH = 32;

	// codes 9 to 15 are unused and decode as NOP
	typedef enum logic [3:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		XOR  = 4'd5,
		SHL  = 4'd6,
		SHR  = 4'd7,
		MOVS = 4'd8
	} opcode_e;

	// instruction fields
	localparam int OP_MSB = 31;
	localparam int OP_LSB = 28;
	localparam int V_BIT = 27;
	localparam int I_BIT = 26;
	localparam int DEST_MSB = 25;
	localparam int DEST_LSB = 21;
	localparam int SRC1_MSB = 20;
	localparam int SRC1_LSB = 16;
	localparam int SRC2_MSB = 15;
	localparam int SRC2_LSB = 11;
	localparam int MASK_MSB = 10;
	localparam int MASK_LSB = 7;
	localparam int IMM_MSB = 6;
	localparam int IMM_LSB = 0;

endpackage

// File: hdl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  logic                             instr_valid_i,
	input  logic [vpu_pkg::INSTR_WIDTH-1:0]  instr_i,
	output logic [vpu_pkg::REG_BITS-1:0]     scalar_sel1_o,
	output logic [vpu_pkg::REG_BITS-1:0]     scalar_sel2_o,
	output logic [vpu_pkg::REG_BITS-1:0]     vector_sel1_o,
	output logic [vpu_pkg::REG_BITS-1:0]     vector_sel2_o,
	output logic                             valid_o,
	output vpu_pkg::opcode_e                 op_o,
	output logic                             is_vector_o,
	output logic                             op1_scalar_o,
	output logic                             op2_imm_o,
	output logic [vpu_pkg::REG_BITS-1:0]     dest_o,
	output logic [vpu_pkg::REG_BITS-1:0]     src1_o,
	output logic [vpu_pkg::REG_BITS-1:0]     src2_o,
	output logic [vpu_pkg::LANES-1:0]        mask_o,
	output logic [DATA_WIDTH-1:0]            imm_o
);

	localparam int IMM_W = vpu_pkg::IMM_MSB - vpu_pkg::IMM_LSB + 1;

	vpu_pkg::opcode_e op;
	logic             is_vec;
	logic             legal;

	assign op = vpu_pkg::opcode_e'(instr_i[vpu_pkg::OP_MSB:vpu_pkg::OP_LSB]);
	assign is_vec = instr_i[vpu_pkg::V_BIT];
	assign legal = (op != vpu_pkg::NOP) && (op <= vpu_pkg::MOVS);

	// register files sample these on the same edge as the fields below
	assign scalar_sel1_o = instr_i[vpu_pkg::SRC1_MSB:vpu_pkg::SRC1_LSB];
	assign scalar_sel2_o = instr_i[vpu_pkg::SRC2_MSB:vpu_pkg::SRC2_LSB];
	assign vector_sel1_o = instr_i[vpu_pkg::SRC1_MSB:vpu_pkg::SRC1_LSB];
	assign vector_sel2_o = instr_i[vpu_pkg::SRC2_MSB:vpu_pkg::SRC2_LSB];

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			valid_o <= 1'b0;
			op_o <= vpu_pkg::NOP;
			is_vector_o <= 1'b0;
			op1_scalar_o <= 1'b0;
			op2_imm_o <= 1'b0;
			dest_o <= '0;
			src1_o <= '0;
			src2_o <= '0;
			mask_o <= '0;
			imm_o <= '0;
		end
		else
		begin
			valid_o <= instr_valid_i && legal;
			op_o <= op;
			is_vector_o <= is_vec;
			// movs takes its source from the scalar file
			op1_scalar_o <= !is_vec || (op == vpu_pkg::MOVS);
			op2_imm_o <= instr_i[vpu_pkg::I_BIT];
			dest_o <= instr_i[vpu_pkg::DEST_MSB:vpu_pkg::DEST_LSB];
			src1_o <= instr_i[vpu_pkg::SRC1_MSB:vpu_pkg::SRC1_LSB];
			src2_o <= instr_i[vpu_pkg::SRC2_MSB:vpu_pkg::SRC2_LSB];
			mask_o <= is_vec ? instr_i[vpu_pkg::MASK_MSB:vpu_pkg::MASK_LSB] : '1;
			imm_o <= {{(DATA_WIDTH - IMM_W){instr_i[vpu_pkg::IMM_MSB]}},
				instr_i[vpu_pkg::IMM_MSB:vpu_pkg::IMM_LSB]};
		end
	end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/10ps

module register_file #(
	parameter int DATA_WIDTH = 32,
	parameter int NUM_LANES = 1
) (
	input  logic                                  clk,
	input  logic                                  rst_n_i,
	input  logic [vpu_pkg::REG_BITS-1:0]          sel1_i,
	input  logic [vpu_pkg::REG_BITS-1:0]          sel2_i,
	input  logic                                  write_en_i,
	input  logic [vpu_pkg::REG_BITS-1:0]          write_reg_i,
	input  logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  write_value_i,
	input  logic [NUM_LANES-1:0]                  write_mask_i,
	output logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  value1_o,
	output logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  value2_o
);

	localparam int NUM_REGS = 1 << vpu_pkg::REG_BITS;

	logic [NUM_LANES-1:0][DATA_WIDTH-1:0] regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int r = 0; r < NUM_REGS; r++)
				regs[r] <= '0;
			value1_o <= '0;
			value2_o <= '0;
		end
		else
		begin
			// same-edge write is not visible to this read
			value1_o <= regs[sel1_i];
			value2_o <= regs[sel2_i];
			for (int lane = 0; lane < NUM_LANES; lane++)
			begin
				if (write_en_i && write_mask_i[lane])
					regs[write_reg_i][lane] <= write_value_i[lane];
			end
		end
	end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/10ps

module execute_stage #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                                        clk,
	input  logic                                        rst_n_i,
	input  logic                                        valid_i,
	input  vpu_pkg::opcode_e                            op_i,
	input  logic                                        is_vector_i,
	input  logic                                        op1_scalar_i,
	input  logic                                        op2_imm_i,
	input  logic [vpu_pkg::REG_BITS-1:0]                dest_i,
	input  logic [vpu_pkg::REG_BITS-1:0]                src1_i,
	input  logic [vpu_pkg::REG_BITS-1:0]                src2_i,
	input  logic [vpu_pkg::LANES-1:0]                   mask_i,
	input  logic [DATA_WIDTH-1:0]                       imm_i,
	input  logic [DATA_WIDTH-1:0]                       scalar_value1_i,
	input  logic [DATA_WIDTH-1:0]                       scalar_value2_i,
	input  logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]   vector_value1_i,
	input  logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]   vector_value2_i,
	input  logic                                        wb_valid_i,
	input  logic                                        wb_is_vector_i,
	input  logic [vpu_pkg::REG_BITS-1:0]                wb_reg_i,
	input  logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]   wb_value_i,
	input  logic [vpu_pkg::LANES-1:0]                   wb_mask_i,
	input  logic                                        rf_valid_i,
	input  logic                                        rf_is_vector_i,
	input  logic [vpu_pkg::REG_BITS-1:0]                rf_reg_i,
	input  logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]   rf_value_i,
	input  logic [vpu_pkg::LANES-1:0]                   rf_mask_i,
	output logic                                        ex_valid_o,
	output logic                                        ex_is_vector_o,
	output logic [vpu_pkg::REG_BITS-1:0]                ex_reg_o,
	output logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]   ex_value_o,
	output logic [vpu_pkg::LANES-1:0]                   ex_mask_o
);

	localparam int SHIFT_BITS = $clog2(DATA_WIDTH);

	// bypass sources, index 0 is the newest
	logic [2:0]                                         byp_valid;
	logic [2:0]                                         byp_vec;
	logic [2:0][vpu_pkg::REG_BITS-1:0]                  byp_reg;
	logic [2:0][vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]     byp_value;
	logic [2:0][vpu_pkg::LANES-1:0]                     byp_mask;
	logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]          op1;
	logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]          op2;
	logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]          result;

	assign byp_valid = {rf_valid_i, wb_valid_i, ex_valid_o};
	assign byp_vec = {rf_is_vector_i, wb_is_vector_i, ex_is_vector_o};
	assign byp_reg = {rf_reg_i, wb_reg_i, ex_reg_o};
	assign byp_value = {rf_value_i, wb_value_i, ex_value_o};
	assign byp_mask = {rf_mask_i, wb_mask_i, ex_mask_o};

	function automatic logic [DATA_WIDTH-1:0] resolve(
		input logic                          want_vec,
		input logic [vpu_pkg::REG_BITS-1:0]  src,
		input int                            lane,
		input logic [DATA_WIDTH-1:0]         base
	);
		logic [DATA_WIDTH-1:0] value;
		value = base;
		// oldest first, so a newer hit overrides
		for (int k = 2; k >= 0; k--)
		begin
			if (byp_valid[k] && (byp_vec[k] == want_vec) && (byp_reg[k] == src)
					&& byp_mask[k][lane])
				value = byp_value[k][lane];
		end
		return value;
	endfunction

	always_comb
	begin
		for (int lane = 0; lane < vpu_pkg::LANES; lane++)
		begin
			// scalar operands live in lane 0 and are broadcast
			if (op1_scalar_i)
				op1[lane] = resolve(1'b0, src1_i, 0, scalar_value1_i);
			else
				op1[lane] = resolve(1'b1, src1_i, lane, vector_value1_i[lane]);
			if (op2_imm_i)
				op2[lane] = imm_i;
			else if (is_vector_i)
				op2[lane] = resolve(1'b1, src2_i, lane, vector_value2_i[lane]);
			else
				op2[lane] = resolve(1'b0, src2_i, 0, scalar_value2_i);
		end
	end

	always_comb
	begin
		for (int lane = 0; lane < vpu_pkg::LANES; lane++)
		begin
			case (op_i)
				vpu_pkg::ADD:  result[lane] = op1[lane] + op2[lane];
				vpu_pkg::SUB:  result[lane] = op1[lane] - op2[lane];
				vpu_pkg::AND:  result[lane] = op1[lane] & op2[lane];
				vpu_pkg::OR:   result[lane] = op1[lane] | op2[lane];
				vpu_pkg::XOR:  result[lane] = op1[lane] ^ op2[lane];
				vpu_pkg::SHL:  result[lane] = op1[lane] << op2[lane][SHIFT_BITS-1:0];
				vpu_pkg::SHR:  result[lane] = op1[lane] >> op2[lane][SHIFT_BITS-1:0];
				vpu_pkg::MOVS: result[lane] = op1[lane];
				default:       result[lane] = '0;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			ex_valid_o <= 1'b0;
			ex_is_vector_o <= 1'b0;
			ex_reg_o <= '0;
			ex_value_o <= '0;
			ex_mask_o <= '0;
		end
		else
		begin
			ex_valid_o <= valid_i;
			ex_is_vector_o <= is_vector_i;
			ex_reg_o <= dest_i;
			ex_value_o <= result;
			ex_mask_o <= mask_i;
		end
	end

endmodule

// File: hdl/writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                                        clk,
	input  logic                                        rst_n_i,
	input  logic                                        ex_valid_i,
	input  logic                                        ex_is_vector_i,
	input  logic [vpu_pkg::REG_BITS-1:0]                ex_reg_i,
	input  logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]   ex_value_i,
	input  logic [vpu_pkg::LANES-1:0]                   ex_mask_i,
	output logic                                        wb_valid_o,
	output logic                                        wb_is_vector_o,
	output logic [vpu_pkg::REG_BITS-1:0]                wb_reg_o,
	output logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]   wb_value_o,
	output logic [vpu_pkg::LANES-1:0]                   wb_mask_o,
	output logic                                        scalar_we_o,
	output logic                                        vector_we_o,
	output logic                                        rf_valid_o,
	output logic                                        rf_is_vector_o,
	output logic [vpu_pkg::REG_BITS-1:0]                rf_reg_o,
	output logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]   rf_value_o,
	output logic [vpu_pkg::LANES-1:0]                   rf_mask_o
);

	assign scalar_we_o = wb_valid_o && !wb_is_vector_o;
	assign vector_we_o = wb_valid_o && wb_is_vector_o;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			wb_valid_o <= 1'b0;
			wb_is_vector_o <= 1'b0;
			wb_reg_o <= '0;
			wb_value_o <= '0;
			wb_mask_o <= '0;
			rf_valid_o <= 1'b0;
			rf_is_vector_o <= 1'b0;
			rf_reg_o <= '0;
			rf_value_o <= '0;
			rf_mask_o <= '0;
		end
		else
		begin
			wb_valid_o <= ex_valid_i;
			wb_is_vector_o <= ex_is_vector_i;
			wb_reg_o <= ex_reg_i;
			wb_value_o <= ex_value_i;
			wb_mask_o <= ex_mask_i;
			// the register file read issued on the write edge still saw the old value
			rf_valid_o <= wb_valid_o;
			rf_is_vector_o <= wb_is_vector_o;
			rf_reg_o <= wb_reg_o;
			rf_value_o <= wb_value_o;
			rf_mask_o <= wb_mask_o;
		end
	end

endmodule

// File: hdl/vector_pipeline.sv
`timescale 1ns/10ps

module vector_pipeline #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                                        clk,
	input  logic                                        rst_n_i,
	input  logic                                        instr_valid_i,
	input  logic [vpu_pkg::INSTR_WIDTH-1:0]             instr_i,
	output logic                                        wb_valid_o,
	output logic                                        wb_is_vector_o,
	output logic [vpu_pkg::REG_BITS-1:0]                wb_reg_o,
	output logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]   wb_value_o,
	output logic [vpu_pkg::LANES-1:0]                   wb_mask_o
);

	logic [vpu_pkg::REG_BITS-1:0]               scalar_sel1;
	logic [vpu_pkg::REG_BITS-1:0]               scalar_sel2;
	logic [vpu_pkg::REG_BITS-1:0]               vector_sel1;
	logic [vpu_pkg::REG_BITS-1:0]               vector_sel2;
	logic                                       ds_valid;
	vpu_pkg::opcode_e                           ds_op;
	logic                                       ds_is_vector;
	logic                                       ds_op1_scalar;
	logic                                       ds_op2_imm;
	logic [vpu_pkg::REG_BITS-1:0]               ds_dest;
	logic [vpu_pkg::REG_BITS-1:0]               ds_src1;
	logic [vpu_pkg::REG_BITS-1:0]               ds_src2;
	logic [vpu_pkg::LANES-1:0]                  ds_mask;
	logic [DATA_WIDTH-1:0]                      ds_imm;
	logic [DATA_WIDTH-1:0]                      scalar_value1;
	logic [DATA_WIDTH-1:0]                      scalar_value2;
	logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]  vector_value1;
	logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]  vector_value2;
	logic                                       ex_valid;
	logic                                       ex_is_vector;
	logic [vpu_pkg::REG_BITS-1:0]               ex_reg;
	logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]  ex_value;
	logic [vpu_pkg::LANES-1:0]                  ex_mask;
	logic                                       scalar_we;
	logic                                       vector_we;
	logic                                       rf_valid;
	logic                                       rf_is_vector;
	logic [vpu_pkg::REG_BITS-1:0]               rf_reg;
	logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]  rf_value;
	logic [vpu_pkg::LANES-1:0]                  rf_mask;

	decode_stage #(.DATA_WIDTH(DATA_WIDTH)) ds (
		.clk(clk), .rst_n_i(rst_n_i), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
		.scalar_sel1_o(scalar_sel1), .scalar_sel2_o(scalar_sel2),
		.vector_sel1_o(vector_sel1), .vector_sel2_o(vector_sel2),
		.valid_o(ds_valid), .op_o(ds_op), .is_vector_o(ds_is_vector),
		.op1_scalar_o(ds_op1_scalar), .op2_imm_o(ds_op2_imm), .dest_o(ds_dest),
		.src1_o(ds_src1), .src2_o(ds_src2), .mask_o(ds_mask), .imm_o(ds_imm));

	// scalar file is one lane wide, fed from lane 0 of the writeback
	register_file #(.DATA_WIDTH(DATA_WIDTH), .NUM_LANES(1)) srf (
		.clk(clk), .rst_n_i(rst_n_i), .sel1_i(scalar_sel1), .sel2_i(scalar_sel2),
		.write_en_i(scalar_we), .write_reg_i(wb_reg_o), .write_value_i(wb_value_o[0]),
		.write_mask_i(wb_mask_o[0]), .value1_o(scalar_value1), .value2_o(scalar_value2));

	register_file #(.DATA_WIDTH(DATA_WIDTH), .NUM_LANES(vpu_pkg::LANES)) vrf (
		.clk(clk), .rst_n_i(rst_n_i), .sel1_i(vector_sel1), .sel2_i(vector_sel2),
		.write_en_i(vector_we), .write_reg_i(wb_reg_o), .write_value_i(wb_value_o),
		.write_mask_i(wb_mask_o), .value1_o(vector_value1), .value2_o(vector_value2));

	execute_stage #(.DATA_WIDTH(DATA_WIDTH)) exs (
		.clk(clk), .rst_n_i(rst_n_i), .valid_i(ds_valid), .op_i(ds_op),
		.is_vector_i(ds_is_vector), .op1_scalar_i(ds_op1_scalar), .op2_imm_i(ds_op2_imm),
		.dest_i(ds_dest), .src1_i(ds_src1), .src2_i(ds_src2), .mask_i(ds_mask),
		.imm_i(ds_imm), .scalar_value1_i(scalar_value1), .scalar_value2_i(scalar_value2),
		.vector_value1_i(vector_value1), .vector_value2_i(vector_value2),
		.wb_valid_i(wb_valid_o), .wb_is_vector_i(wb_is_vector_o), .wb_reg_i(wb_reg_o),
		.wb_value_i(wb_value_o), .wb_mask_i(wb_mask_o),
		.rf_valid_i(rf_valid), .rf_is_vector_i(rf_is_vector), .rf_reg_i(rf_reg),
		.rf_value_i(rf_value), .rf_mask_i(rf_mask),
		.ex_valid_o(ex_valid), .ex_is_vector_o(ex_is_vector), .ex_reg_o(ex_reg),
		.ex_value_o(ex_value), .ex_mask_o(ex_mask));

	writeback_stage #(.DATA_WIDTH(DATA_WIDTH)) wbs (
		.clk(clk), .rst_n_i(rst_n_i), .ex_valid_i(ex_valid), .ex_is_vector_i(ex_is_vector),
		.ex_reg_i(ex_reg), .ex_value_i(ex_value), .ex_mask_i(ex_mask),
		.wb_valid_o(wb_valid_o), .wb_is_vector_o(wb_is_vector_o), .wb_reg_o(wb_reg_o),
		.wb_value_o(wb_value_o), .wb_mask_o(wb_mask_o),
		.scalar_we_o(scalar_we), .vector_we_o(vector_we),
		.rf_valid_o(rf_valid), .rf_is_vector_o(rf_is_vector), .rf_reg_o(rf_reg),
		.rf_value_o(rf_value), .rf_mask_o(rf_mask));

endmodule

// File: sim/vector_pipeline_properties.sv
`timescale 1ns/10ps

module vector_pipeline_properties #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                                        clk,
	input  logic                                        rst_n_i,
	input  logic                                        instr_valid_i,
	input  logic                                        wb_valid_i,
	input  logic                                        wb_is_vector_i,
	input  logic [vpu_pkg::REG_BITS-1:0]                wb_reg_i,
	input  logic [vpu_pkg::LANES-1:0][DATA_WIDTH-1:0]   wb_value_i,
	input  logic [vpu_pkg::LANES-1:0]                   wb_mask_i,
	input  logic                                        scalar_we_i,
	input  logic                                        vector_we_i
);

	// fixed latency, the instruction was sampled three edges back
	assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_valid_i |-> $past(instr_valid_i, 3))
	else
		$error("writeback without an instruction three cycles earlier");

	// decode forces a full mask on scalar instructions
	assert property (@(posedge clk) disable iff (!rst_n_i)
		scalar_we_i |-> (wb_mask_i == '1))
	else
		$error("scalar write without a full lane mask");

	assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_valid_i |-> !$isunknown({wb_is_vector_i, wb_reg_i, wb_value_i, wb_mask_i}))
	else
		$error("unknown value on the writeback outputs");

endmodule

bind vector_pipeline vector_pipeline_properties #(.DATA_WIDTH(DATA_WIDTH)) props (
	.clk(clk), .rst_n_i(rst_n_i), .instr_valid_i(instr_valid_i),
	.wb_valid_i(wb_valid_o), .wb_is_vector_i(wb_is_vector_o), .wb_reg_i(wb_reg_o),
	.wb_value_i(wb_value_o), .wb_mask_i(wb_mask_o),
	.scalar_we_i(scalar_we), .vector_we_i(vector_we));

// File: sim/vector_pipeline_tb.sv
`timescale 1ns/10ps

module vector_pipeline_tb;

	localparam int DW = 32;
	localparam int SLOT_COUNT = 400;
	localparam int WATCHDOG_NS = SLOT_COUNT * 20 * 2 + 2000;

	typedef struct packed {
		logic                                valid;
		logic                                vec;
		logic [vpu_pkg::REG_BITS-1:0]        dest;
		logic [vpu_pkg::LANES-1:0]           mask;
		logic [vpu_pkg::LANES-1:0][DW-1:0]   value;
	} wb_entry_t;

	logic                                    clk;
	logic                                    rst_n_i;
	logic                                    instr_valid_i;
	logic [vpu_pkg::INSTR_WIDTH-1:0]         instr_i;
	logic                                    wb_valid_o;
	logic                                    wb_is_vector_o;
	logic [vpu_pkg::REG_BITS-1:0]            wb_reg_o;
	logic [vpu_pkg::LANES-1:0][DW-1:0]       wb_value_o;
	logic [vpu_pkg::LANES-1:0]               wb_mask_o;

	logic [DW-1:0]                           s_model [32];
	logic [vpu_pkg::LANES-1:0][DW-1:0]       v_model [32];
	wb_entry_t                               pending [$];
	integer                                  seed;
	int                                      errors;
	int                                      checks;

	vector_pipeline #(.DATA_WIDTH(DW)) uut (
		.clk(clk), .rst_n_i(rst_n_i), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
		.wb_valid_o(wb_valid_o), .wb_is_vector_o(wb_is_vector_o), .wb_reg_o(wb_reg_o),
		.wb_value_o(wb_value_o), .wb_mask_o(wb_mask_o));

	initial
		clk = 1'b0;

	always #10 clk = ~clk;

	function automatic logic [DW-1:0] sign_extend(input logic [6:0] imm);
		return {{(DW - 7){imm[6]}}, imm};
	endfunction

	function automatic logic [DW-1:0] alu_result(input logic [3:0] op, input logic [DW-1:0] a,
			input logic [DW-1:0] b);
		case (op)
			vpu_pkg::ADD:  return a + b;
			vpu_pkg::SUB:  return a - b;
			vpu_pkg::AND:  return a & b;
			vpu_pkg::OR:   return a | b;
			vpu_pkg::XOR:  return a ^ b;
			vpu_pkg::SHL:  return a << b[4:0];
			vpu_pkg::SHR:  return a >> b[4:0];
			vpu_pkg::MOVS: return a;
			default:       return '0;
		endcase
	endfunction

	task automatic mismatch(input string name, input logic [DW-1:0] expected,
			input logic [DW-1:0] actual);
		errors++;
		$display("Error at %0t: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
	endtask

	task automatic check_wb(input wb_entry_t e);
		checks++;
		assert (wb_valid_o === e.valid)
		else
			mismatch("wb_valid_o", DW'(e.valid), DW'(wb_valid_o));
		if (e.valid)
		begin
			assert (wb_is_vector_o === e.vec)
			else
				mismatch("wb_is_vector_o", DW'(e.vec), DW'(wb_is_vector_o));
			assert (wb_reg_o === e.dest)
			else
				mismatch("wb_reg_o", DW'(e.dest), DW'(wb_reg_o));
			assert (wb_mask_o === e.mask)
			else
				mismatch("wb_mask_o", DW'(e.mask), DW'(wb_mask_o));
			// scalar results only live in lane 0
			for (int lane = 0; lane < vpu_pkg::LANES; lane++)
			begin
				if (e.mask[lane] && (e.vec || lane == 0))
					assert (wb_value_o[lane] === e.value[lane])
					else
						mismatch($sformatf("wb_value_o[%0d]", lane), e.value[lane],
							wb_value_o[lane]);
			end
		end
	endtask

	// wb_* of the slot driven three falling edges ago is stable here
	task automatic drive_slot(input logic valid, input logic [31:0] word, input wb_entry_t e);
		@(negedge clk);
		if (pending.size() == 3)
			check_wb(pending.pop_front());
		instr_valid_i = valid;
		instr_i = word;
		pending.push_back(e);
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++)
			drive_slot(1'b0, '0, '0);
	endtask

	task automatic issue(input logic [3:0] op, input logic vec, input logic use_imm,
			input logic [4:0] dest, input logic [4:0] src1, input logic [4:0] src2,
			input logic [3:0] mask, input logic [6:0] imm);
		wb_entry_t                          e;
		logic [vpu_pkg::LANES-1:0][DW-1:0]  res;
		logic [DW-1:0]                      a;
		logic [DW-1:0]                      b;
		e = '0;
		res = '0;
		if (op != 4'd0 && op <= 4'd8)
		begin
			for (int lane = 0; lane < vpu_pkg::LANES; lane++)
			begin
				a = (vec && op != 4'd8) ? v_model[src1][lane] : s_model[src1];
				if (use_imm)
					b = sign_extend(imm);
				else
					b = vec ? v_model[src2][lane] : s_model[src2];
				res[lane] = alu_result(op, a, b);
			end
			if (!vec)
				s_model[dest] = res[0];
			for (int lane = 0; lane < vpu_pkg::LANES; lane++)
			begin
				if (vec && mask[lane])
					v_model[dest][lane] = res[lane];
			end
			e.valid = 1'b1;
			e.vec = vec;
			e.dest = dest;
			e.mask = vec ? mask : 4'hf;
			e.value = res;
		end
		drive_slot(1'b1, {op, vec, use_imm, dest, src1, src2, mask, imm}, e);
	endtask

	task automatic reset_and_nops();
		idle(5);
		issue(vpu_pkg::NOP, 1'b0, 1'b0, 5'd3, 5'd1, 5'd2, 4'h0, 7'd0);
		issue(4'd9, 1'b1, 1'b0, 5'd3, 5'd1, 5'd2, 4'hf, 7'd0);
		issue(4'd15, 1'b0, 1'b1, 5'd3, 5'd1, 5'd2, 4'h0, 7'h7f);
		idle(2);
		issue(vpu_pkg::ADD, 1'b0, 1'b0, 5'd5, 5'd0, 5'd0, 4'h0, 7'd0);
		idle(4);
	endtask

	task automatic scalar_alu();
		logic [31:0] rnd;
		logic [3:0]  op;
		for (int k = 1; k <= 7; k++)
		begin
			rnd = $random(seed);
			op = k[3:0];
			issue(vpu_pkg::ADD, 1'b0, 1'b1, 5'd1, 5'd0, 5'd0, 4'h0, rnd[6:0]);
			idle(4);
			issue(vpu_pkg::ADD, 1'b0, 1'b1, 5'd2, 5'd0, 5'd0, 4'h0, rnd[13:7]);
			idle(4);
			issue(op, 1'b0, 1'b0, 5'd3, 5'd1, 5'd2, 4'h0, 7'd0);
			idle(4);
		end
	endtask

	task automatic scalar_forwarding();
		logic [31:0] rnd;
		for (int d = 1; d <= 4; d++)
		begin
			rnd = $random(seed);
			issue(vpu_pkg::ADD, 1'b0, 1'b1, 5'd6, 5'd0, 5'd0, 4'h0, rnd[6:0]);
			idle(4);
			issue(vpu_pkg::ADD, 1'b0, 1'b1, 5'd7, 5'd6, 5'd0, 4'h0, rnd[13:7]);
			idle(d - 1);
			// both operand ports read the producer
			issue(vpu_pkg::ADD, 1'b0, 1'b0, 5'd8, 5'd7, 5'd7, 4'h0, 7'd0);
			idle(4);
		end
	endtask

	task automatic vector_masking();
		logic [31:0] rnd;
		rnd = $random(seed);
		issue(vpu_pkg::ADD, 1'b0, 1'b1, 5'd9, 5'd0, 5'd0, 4'h0, rnd[6:0]);
		issue(vpu_pkg::ADD, 1'b0, 1'b1, 5'd10, 5'd0, 5'd0, 4'h0, rnd[13:7]);
		issue(vpu_pkg::MOVS, 1'b1, 1'b0, 5'd1, 5'd9, 5'd0, 4'hf, 7'd0);
		// each lane of v4 ends at a different writer distance
		issue(vpu_pkg::ADD, 1'b1, 1'b1, 5'd4, 5'd1, 5'd0, 4'b0011, rnd[20:14]);
		issue(vpu_pkg::XOR, 1'b1, 1'b1, 5'd4, 5'd1, 5'd0, 4'b0100, rnd[27:21]);
		issue(vpu_pkg::MOVS, 1'b1, 1'b0, 5'd4, 5'd10, 5'd0, 4'b1000, 7'd0);
		issue(vpu_pkg::SUB, 1'b1, 1'b1, 5'd4, 5'd1, 5'd0, 4'b0001, 7'd5);
		issue(vpu_pkg::OR, 1'b1, 1'b0, 5'd5, 5'd4, 5'd1, 4'hf, 7'd0);
		issue(vpu_pkg::ADD, 1'b1, 1'b0, 5'd6, 5'd4, 5'd4, 4'h0, 7'd0);
		idle(2);
		issue(vpu_pkg::ADD, 1'b1, 1'b0, 5'd7, 5'd4, 5'd5, 4'hf, 7'd0);
		idle(4);
	endtask

	task automatic random_stream();
		logic [31:0] rnd;
		logic [3:0]  op;
		for (int i = 0; i < 200; i++)
		begin
			rnd = $random(seed);
			// kind 2 picks an unused code, wrapping onto NOP
			if (rnd[3:0] == 4'd2)
				op = 4'd9 + {1'b0, rnd[6:4]};
			else
				op = 4'd1 + {1'b0, rnd[6:4]};
			if (rnd[3:0] < 4'd2)
				idle(1);
			else
				issue(op, rnd[7], rnd[8], {2'b00, rnd[11:9]}, {2'b00, rnd[14:12]},
					{2'b00, rnd[17:15]}, rnd[21:18], rnd[28:22]);
		end
		idle(4);
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Error: watchdog expired at %0t before the tests finished", $time);
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		seed = 63328;
		errors = 0;
		checks = 0;
		rst_n_i = 1'b0;
		instr_valid_i = 1'b0;
		instr_i = '0;
		for (int r = 0; r < 32; r++)
		begin
			s_model[r] = '0;
			v_model[r] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		reset_and_nops();
		scalar_alu();
		scalar_forwarding();
		vector_masking();
		random_stream();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: flist.f
hdl/vpu_pkg.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/vector_pipeline.sv
sim/vector_pipeline_properties.sv
sim/vector_pipeline_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module vector_pipeline_tb \
	-Mdir obj_dir -f flist.f
if ! ./obj_dir/Vvector_pipeline_tb > sim.log 2>&1
then
	cat sim.log
	exit 1
fi
cat sim.log
if grep -q "Done: errors found" sim.log
then
	exit 1
fi
